// ==== rtl/rv_core.sv ====
`default_nettype none

module rv_core #(
    parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    output logic [rv_core_pkg::XLEN-1:0]       imem_addr_o,
    input  logic [rv_core_pkg::XLEN-1:0]       imem_rdata_i,
    output logic                               dmem_req_valid_o,
    input  logic                               dmem_ready_i,
    output logic                               dmem_we_o,
    output logic [rv_core_pkg::XLEN-1:0]       dmem_addr_o,
    output logic [rv_core_pkg::XLEN-1:0]       dmem_wdata_o,
    input  logic [rv_core_pkg::XLEN-1:0]       dmem_rdata_i,
    output logic                               retire_valid_o,
    output logic [rv_core_pkg::XLEN-1:0]       retire_pc_o,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] retire_rd_o,
    output logic [rv_core_pkg::XLEN-1:0]       retire_wdata_o,
    output logic                               retire_we_o
);
    import rv_core_pkg::*;

    instr_u                instr;
    logic [XLEN-1:0]       pc;
    logic                  instr_valid;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;
    logic                  pc_wen;
    logic [XLEN-1:0]       next_pc;

    dec_exu_if u_dec_exu ();
    exu_lsu_if u_exu_lsu ();

    rv_fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .imem_addr_o   (imem_addr_o),
        .imem_rdata_i  (imem_rdata_i),
        .pc_wen_i      (pc_wen),
        .next_pc_i     (next_pc),
        .instr_o       (instr),
        .pc_o          (pc),
        .instr_valid_o (instr_valid)
    );

    rv_decode u_decode (
        .instr_i       (instr),
        .pc_i          (pc),
        .instr_valid_i (instr_valid),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .dec           (u_dec_exu.drv)
    );

    rv_regfile u_regfile (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata)
    );

    rv_execute u_execute (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .dec      (u_dec_exu.rdr),
        .exu      (u_exu_lsu.drv)
    );

    // Memory access, register writeback and retire report
    rv_lsu_wb u_lsu_wb (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .exu              (u_exu_lsu.rdr),
        .dmem_req_valid_o (dmem_req_valid_o),
        .dmem_ready_i     (dmem_ready_i),
        .dmem_we_o        (dmem_we_o),
        .dmem_addr_o      (dmem_addr_o),
        .dmem_wdata_o     (dmem_wdata_o),
        .dmem_rdata_i     (dmem_rdata_i),
        .rf_we_o          (rf_we),
        .rf_waddr_o       (rf_waddr),
        .rf_wdata_o       (rf_wdata),
        .pc_wen_o         (pc_wen),
        .next_pc_o        (next_pc),
        .retire_valid_o   (retire_valid_o),
        .retire_pc_o      (retire_pc_o),
        .retire_rd_o      (retire_rd_o),
        .retire_wdata_o   (retire_wdata_o),
        .retire_we_o      (retire_we_o)
    );

endmodule

`default_nettype wire

// ==== rtl/rv_core_if.sv ====
`default_nettype none

// Decoded instruction on its way to execute
interface dec_exu_if;
    import rv_core_pkg::*;

    logic                  valid;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    logic                  is_branch;
    logic                  branch_ne;
    logic                  is_jal;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       pc;
    mem_kind_e             mem_kind;
    logic [XLEN-1:0]       store_data;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_we;

    modport drv (output valid, alu_op, op_a, op_b, is_branch, branch_ne, is_jal,
                 imm, pc, mem_kind, store_data, rd, rd_we);
    modport rdr (input valid, alu_op, op_a, op_b, is_branch, branch_ne, is_jal,
                 imm, pc, mem_kind, store_data, rd, rd_we);
endinterface

// Execute result register towards memory and writeback
interface exu_lsu_if;
    import rv_core_pkg::*;

    logic                  valid;
    // Writeback has taken the instruction
    logic                  ready;
    mem_kind_e             mem_kind;
    logic [XLEN-1:0]       result;
    logic [XLEN-1:0]       store_data;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_we;
    logic [XLEN-1:0]       next_pc;
    logic [XLEN-1:0]       pc;

    modport drv (output valid, mem_kind, result, store_data, rd, rd_we, next_pc, pc,
                 input ready);
    modport rdr (input valid, mem_kind, result, store_data, rd, rd_we, next_pc, pc,
                 output ready);
endinterface

`default_nettype wire

// ==== rtl/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Instruction formats, fields from MSB down
    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } j_fmt_t;

    // One instruction word seen through every format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_kind_e;

endpackage

`default_nettype wire

// ==== rtl/rv_decode.sv ====
`default_nettype none

module rv_decode (
    input  rv_core_pkg::instr_u                instr_i,
    input  logic [rv_core_pkg::XLEN-1:0]       pc_i,
    input  logic                               instr_valid_i,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [rv_core_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [rv_core_pkg::XLEN-1:0]       rs2_data_i,
    dec_exu_if.drv                             dec
);
    import rv_core_pkg::*;

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    // Shared funct3 table of OP and OP-IMM
    function automatic alu_op_e alu_from_funct3(input logic [2:0] funct3, input logic sub);
        case (funct3)
            3'b000:  return sub ? ALU_SUB : ALU_ADD;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    // Sign-extended immediates, one per format
    assign imm_i = {{20{instr_i.i_fmt.imm_11_0[11]}}, instr_i.i_fmt.imm_11_0};
    assign imm_s = {{20{instr_i.s_fmt.imm_11_5[6]}},
                    instr_i.s_fmt.imm_11_5, instr_i.s_fmt.imm_4_0};
    assign imm_b = {{20{instr_i.b_fmt.imm_12}}, instr_i.b_fmt.imm_11,
                    instr_i.b_fmt.imm_10_5, instr_i.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {instr_i.u_fmt.imm_31_12, 12'b0};
    assign imm_j = {{12{instr_i.j_fmt.imm_20}}, instr_i.j_fmt.imm_19_12,
                    instr_i.j_fmt.imm_11, instr_i.j_fmt.imm_10_1, 1'b0};

    assign rs1_addr_o = instr_i.r_fmt.rs1;
    assign rs2_addr_o = instr_i.r_fmt.rs2;

    assign dec.valid      = instr_valid_i;
    assign dec.pc         = pc_i;
    assign dec.store_data = rs2_data_i;
    assign dec.rd         = instr_i.r_fmt.rd;

    always_comb begin
        // Unknown opcodes fall through as a no-op
        dec.alu_op    = ALU_ADD;
        dec.op_a      = rs1_data_i;
        dec.op_b      = imm_i;
        dec.imm       = imm_i;
        dec.is_branch = 1'b0;
        dec.branch_ne = 1'b0;
        dec.is_jal    = 1'b0;
        dec.mem_kind  = MEM_NONE;
        dec.rd_we     = 1'b0;
        case (opcode_e'(instr_i.r_fmt.opcode))
            OPC_OP: begin
                dec.alu_op = alu_from_funct3(instr_i.r_fmt.funct3, instr_i.r_fmt.funct7[5]);
                dec.op_b   = rs2_data_i;
                dec.rd_we  = 1'b1;
            end
            OPC_OP_IMM: begin
                dec.alu_op = alu_from_funct3(instr_i.i_fmt.funct3, 1'b0);
                dec.rd_we  = 1'b1;
            end
            OPC_LUI: begin
                dec.alu_op = ALU_PASS_B;
                dec.op_a   = '0;
                dec.op_b   = imm_u;
                dec.imm    = imm_u;
                dec.rd_we  = 1'b1;
            end
            OPC_LOAD: begin
                dec.mem_kind = MEM_LOAD;
                dec.rd_we    = 1'b1;
            end
            OPC_STORE: begin
                dec.op_b     = imm_s;
                dec.imm      = imm_s;
                dec.mem_kind = MEM_STORE;
            end
            OPC_BRANCH: begin
                // BEQ and BNE differ only in funct3 bit 0
                dec.op_b      = rs2_data_i;
                dec.imm       = imm_b;
                dec.is_branch = 1'b1;
                dec.branch_ne = instr_i.b_fmt.funct3[0];
            end
            OPC_JAL: begin
                dec.imm    = imm_j;
                dec.is_jal = 1'b1;
                dec.rd_we  = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/rv_execute.sv ====
`default_nettype none

module rv_execute (
    input  logic   clk_i,
    input  logic   arst_n_i,
    dec_exu_if.rdr dec,
    exu_lsu_if.drv exu
);
    import rv_core_pkg::*;

    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] pc_plus4;
    logic            taken;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD: alu_res = dec.op_a + dec.op_b;
            ALU_SUB: alu_res = dec.op_a - dec.op_b;
            ALU_AND: alu_res = dec.op_a & dec.op_b;
            ALU_OR:  alu_res = dec.op_a | dec.op_b;
            ALU_XOR: alu_res = dec.op_a ^ dec.op_b;
            ALU_SLT: alu_res = {{(XLEN-1){1'b0}}, $signed(dec.op_a) < $signed(dec.op_b)};
            default: alu_res = dec.op_b;
        endcase
    end

    assign pc_plus4 = dec.pc + XLEN'(4);

    // Branch compares op_a against op_b, BNE inverts the test
    assign taken = dec.is_jal ||
                   (dec.is_branch && ((dec.op_a == dec.op_b) != dec.branch_ne));

    // In-flight flag, held until writeback takes the instruction
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exu.valid <= 1'b0;
        end else if (exu.valid) begin
            exu.valid <= !exu.ready;
        end else begin
            exu.valid <= dec.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dec.valid && !exu.valid) begin
            exu.mem_kind   <= dec.mem_kind;
            exu.result     <= dec.is_jal ? pc_plus4 : alu_res;
            exu.store_data <= dec.store_data;
            exu.rd         <= dec.rd;
            exu.rd_we      <= dec.rd_we;
            exu.next_pc    <= taken ? dec.pc + dec.imm : pc_plus4;
            exu.pc         <= dec.pc;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rv_fetch.sv ====
`default_nettype none

module rv_fetch #(
    parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    output logic [rv_core_pkg::XLEN-1:0] imem_addr_o,
    input  logic [rv_core_pkg::XLEN-1:0] imem_rdata_i,
    input  logic                         pc_wen_i,
    input  logic [rv_core_pkg::XLEN-1:0] next_pc_i,
    output rv_core_pkg::instr_u          instr_o,
    output logic [rv_core_pkg::XLEN-1:0] pc_o,
    output logic                         instr_valid_o
);

    assign imem_addr_o = pc_o;

    // PC and instruction-held flag
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_o          <= RESET_PC;
            instr_valid_o <= 1'b0;
        end else if (pc_wen_i) begin
            pc_o          <= next_pc_i;
            instr_valid_o <= 1'b0;
        end else if (!instr_valid_o) begin
            instr_valid_o <= 1'b1;
        end
    end

    // Instruction latch, loads while nothing is held
    always_ff @(posedge clk_i) begin
        if (!instr_valid_o && !pc_wen_i) begin
            instr_o <= imem_rdata_i;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rv_lsu_wb.sv ====
`default_nettype none

module rv_lsu_wb (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    exu_lsu_if.rdr                             exu,
    output logic                               dmem_req_valid_o,
    input  logic                               dmem_ready_i,
    output logic                               dmem_we_o,
    output logic [rv_core_pkg::XLEN-1:0]       dmem_addr_o,
    output logic [rv_core_pkg::XLEN-1:0]       dmem_wdata_o,
    input  logic [rv_core_pkg::XLEN-1:0]       dmem_rdata_i,
    output logic                               rf_we_o,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rf_waddr_o,
    output logic [rv_core_pkg::XLEN-1:0]       rf_wdata_o,
    output logic                               pc_wen_o,
    output logic [rv_core_pkg::XLEN-1:0]       next_pc_o,
    output logic                               retire_valid_o,
    output logic [rv_core_pkg::XLEN-1:0]       retire_pc_o,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] retire_rd_o,
    output logic [rv_core_pkg::XLEN-1:0]       retire_wdata_o,
    output logic                               retire_we_o
);
    import rv_core_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        MEM_WAIT,
        WRITEBACK
    } state_e;

    state_e          state_q;
    state_e          state_d;
    logic            is_mem;
    logic            wb_fire;
    logic [XLEN-1:0] load_q;
    logic [XLEN-1:0] wb_data;

    assign is_mem = exu.mem_kind != MEM_NONE;

    // Request fields come straight from the execute register, stable while waiting
    assign dmem_req_valid_o = exu.valid && is_mem && (state_q != WRITEBACK);
    assign dmem_we_o        = exu.mem_kind == MEM_STORE;
    assign dmem_addr_o      = exu.result;
    assign dmem_wdata_o     = exu.store_data;

    // Non-memory instructions write back straight from IDLE
    assign wb_fire   = (state_q == WRITEBACK) || (state_q == IDLE && exu.valid && !is_mem);
    assign exu.ready = wb_fire;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (dmem_req_valid_o) begin
                    state_d = dmem_ready_i ? WRITEBACK : MEM_WAIT;
                end
            end
            MEM_WAIT: begin
                if (dmem_ready_i) begin
                    state_d = WRITEBACK;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Load data sampled in the ready cycle
    always_ff @(posedge clk_i) begin
        if (dmem_req_valid_o && dmem_ready_i) begin
            load_q <= dmem_rdata_i;
        end
    end

    assign wb_data = (exu.mem_kind == MEM_LOAD) ? load_q : exu.result;

    assign rf_we_o    = wb_fire && exu.rd_we;
    assign rf_waddr_o = exu.rd;
    assign rf_wdata_o = wb_data;
    assign pc_wen_o   = wb_fire;
    assign next_pc_o  = exu.next_pc;

    assign retire_valid_o = wb_fire;
    assign retire_pc_o    = exu.pc;
    assign retire_rd_o    = exu.rd;
    assign retire_wdata_o = wb_data;
    assign retire_we_o    = exu.rd_we;

endmodule

`default_nettype wire

// ==== rtl/rv_regfile.sv ====
`default_nettype none

module rv_regfile (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [rv_core_pkg::XLEN-1:0]       rdata1_o,
    output logic [rv_core_pkg::XLEN-1:0]       rdata2_o,
    input  logic                               we_i,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [rv_core_pkg::XLEN-1:0]       wdata_i
);
    import rv_core_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    // x0 is cleared by reset and never written
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

endmodule

`default_nettype wire

// ==== rv_core.f ====
rtl/rv_core_pkg.sv
rtl/rv_core_if.sv
rtl/rv_regfile.sv
rtl/rv_fetch.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_lsu_wb.sv
rtl/rv_core.sv
tests/tb_rv_core.sv

// ==== tests/tb_rv_core.sv ====
`default_nettype none

module tb_rv_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] RESET_PC   = 32'h0000_0100;
    localparam int          PROG_WORDS = 400;
    localparam int          RETIRES    = 150;
    localparam int          NUM_TESTS  = 3;
    localparam int          TIMEOUT    = RETIRES * 7 + 20;
    localparam logic [31:0] NOP        = 32'h0000_0013;

    logic        clk_i;
    logic        arst_n_i;
    logic [31:0] imem_addr_o;
    logic [31:0] imem_rdata_i;
    logic        dmem_req_valid_o;
    logic        dmem_ready_i;
    logic        dmem_we_o;
    logic [31:0] dmem_addr_o;
    logic [31:0] dmem_wdata_o;
    logic [31:0] dmem_rdata_i;
    logic        retire_valid_o;
    logic [31:0] retire_pc_o;
    logic [4:0]  retire_rd_o;
    logic [31:0] retire_wdata_o;
    logic        retire_we_o;

    logic [31:0] rng;
    logic [31:0] imem [PROG_WORDS];
    logic [31:0] dmem [64];
    logic [31:0] model_mem [64];
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;

    // Expected retire, filled by the model
    logic [31:0] exp_pc;
    logic [4:0]  exp_rd;
    logic        exp_we;
    logic [31:0] exp_wdata;
    logic        exp_mem;
    logic        exp_store;
    logic [31:0] exp_addr;
    logic [31:0] exp_sdata;

    // Data-memory transfer seen since the last retire
    logic        req_open;
    logic        req_done;
    logic        req_we;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    int          stall_left;
    int          stalls;
    logic        held_valid;
    logic        held_we;
    logic [31:0] held_addr;
    logic [31:0] held_wdata;

    int errors;
    int bad_tests;
    int test_cycle;

    rv_core #(
        .RESET_PC (RESET_PC)
    ) dut_i (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .imem_addr_o      (imem_addr_o),
        .imem_rdata_i     (imem_rdata_i),
        .dmem_req_valid_o (dmem_req_valid_o),
        .dmem_ready_i     (dmem_ready_i),
        .dmem_we_o        (dmem_we_o),
        .dmem_addr_o      (dmem_addr_o),
        .dmem_wdata_o     (dmem_wdata_o),
        .dmem_rdata_i     (dmem_rdata_i),
        .retire_valid_o   (retire_valid_o),
        .retire_pc_o      (retire_pc_o),
        .retire_rd_o      (retire_rd_o),
        .retire_wdata_o   (retire_wdata_o),
        .retire_we_o      (retire_we_o)
    );

    always #2 clk_i = ~clk_i;

    // Cycle budget per test, worst case 7 cycles per retire
    always @(posedge clk_i) begin
        if (test_cycle > TIMEOUT) begin
            $display("timeout: core stopped retiring after %0d cycles", test_cycle);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return (next_rand() >> 16) % n;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b9) ^ {addr[7:0], 24'h5a0f3c};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - RESET_PC) >> 2;
        if (idx < PROG_WORDS) begin
            return imem[idx];
        end else begin
            return NOP;
        end
    endfunction

    // Registers limited to x0..x7 so results feed later instructions
    function automatic logic [31:0] make_instr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] r;
        logic [12:0] boff;
        logic [20:0] joff;
        logic [11:0] moff;
        rd   = 5'(rand_below(8));
        rs1  = 5'(rand_below(8));
        rs2  = 5'(rand_below(8));
        r    = next_rand();
        boff = (rand_below(2) != 0) ? 13'd12 : 13'd8;
        joff = 21'(boff);
        moff = 12'(rand_below(64) * 4);
        case (rand_below(13))
            0:  return {7'h00, rs2, rs1, 3'd0, rd, 7'h33};
            1:  return {7'h20, rs2, rs1, 3'd0, rd, 7'h33};
            2:  return {7'h00, rs2, rs1, 3'd7, rd, 7'h33};
            3:  return {7'h00, rs2, rs1, 3'd6, rd, 7'h33};
            4:  return {7'h00, rs2, rs1, 3'd4, rd, 7'h33};
            5:  return {7'h00, rs2, rs1, 3'd2, rd, 7'h33};
            6:  return {r[11:0], rs1, 3'd0, rd, 7'h13};
            7:  return {r[31:12], rd, 7'h37};
            8:  return {moff, 5'd0, 3'd2, rd, 7'h03};
            9:  return {moff[11:5], rs2, 5'd0, 3'd2, moff[4:0], 7'h23};
            10: return {boff[12], boff[10:5], rs2, rs1, 3'd0, boff[4:1], boff[11], 7'h63};
            11: return {boff[12], boff[10:5], rs2, rs1, 3'd1, boff[4:1], boff[11], 7'h63};
            default: return {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'h6f};
        endcase
    endfunction

    task automatic build_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            imem[i] = make_instr();
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i]      = fill_word(i * 4);
            model_mem[i] = fill_word(i * 4);
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        model_pc = RESET_PC;
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Instruction-set model, one instruction per call
    task automatic step_model();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] next_pc;
        w     = fetch_word(model_pc);
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        exp_pc    = model_pc;
        exp_rd    = w[11:7];
        exp_we    = 1'b1;
        exp_wdata = '0;
        exp_mem   = 1'b0;
        exp_store = 1'b0;
        exp_addr  = '0;
        exp_sdata = b;
        next_pc   = model_pc + 32'd4;
        case (w[6:0])
            7'h33: begin
                case (w[14:12])
                    3'd0:    exp_wdata = w[30] ? a - b : a + b;
                    3'd2:    exp_wdata = {31'b0, $signed(a) < $signed(b)};
                    3'd4:    exp_wdata = a ^ b;
                    3'd6:    exp_wdata = a | b;
                    default: exp_wdata = a & b;
                endcase
            end
            7'h13: exp_wdata = a + imm_i;
            7'h37: exp_wdata = {w[31:12], 12'b0};
            7'h03: begin
                exp_mem   = 1'b1;
                exp_addr  = a + imm_i;
                exp_wdata = model_mem[exp_addr[7:2]];
            end
            7'h23: begin
                exp_mem   = 1'b1;
                exp_store = 1'b1;
                exp_we    = 1'b0;
                exp_addr  = a + imm_s;
                model_mem[exp_addr[7:2]] = b;
            end
            7'h63: begin
                exp_we = 1'b0;
                if ((a == b) != w[12]) begin
                    next_pc = model_pc + imm_b;
                end
            end
            7'h6f: begin
                exp_wdata = model_pc + 32'd4;
                next_pc   = model_pc + imm_j;
            end
            default: exp_we = 1'b0;
        endcase
        if (exp_we && (exp_rd != 5'd0)) begin
            model_regs[exp_rd] = exp_wdata;
        end
        model_pc = next_pc;
    endtask

    task automatic check_retire(input int gap);
        int exp_gap;
        step_model();
        exp_gap = exp_mem ? 4 + stalls : 3;
        assert (gap == exp_gap) else begin
            $display("retire at %0t came %0d cycles after the previous one instead of %0d",
                     $time, gap, exp_gap);
            errors++;
        end
        check_eq("retire_pc_o", retire_pc_o, exp_pc);
        check_eq("retire_we_o", retire_we_o, exp_we);
        if (exp_we) begin
            check_eq("retire_rd_o", retire_rd_o, exp_rd);
            check_eq("retire_wdata_o", retire_wdata_o, exp_wdata);
        end
        if (exp_mem) begin
            assert (req_done) else begin
                $display("memory instruction at pc %h retired without a data transfer", exp_pc);
                errors++;
            end
            if (req_done) begin
                check_eq("dmem_we_o", req_we, exp_store);
                check_eq("dmem_addr_o", req_addr, exp_addr);
                if (exp_store) begin
                    check_eq("dmem_wdata_o", req_wdata, exp_sdata);
                end
            end
        end else begin
            assert (!req_done) else begin
                $display("instruction at pc %h made a data transfer it should not", exp_pc);
                errors++;
            end
        end
        req_done = 1'b0;
        stalls   = 0;
    endtask

    // Instruction word and data-memory responder, called on each falling edge
    task automatic drive_inputs();
        imem_rdata_i = fetch_word(imem_addr_o);
        if (dmem_req_valid_o) begin
            if (!req_open) begin
                stall_left = rand_below(4);
                req_open   = 1'b1;
            end
            dmem_rdata_i = dmem[dmem_addr_o[7:2]];
            if (stall_left == 0) begin
                dmem_ready_i = 1'b1;
                req_open     = 1'b0;
                req_done     = 1'b1;
                req_we       = dmem_we_o;
                req_addr     = dmem_addr_o;
                req_wdata    = dmem_wdata_o;
                if (dmem_we_o) begin
                    dmem[dmem_addr_o[7:2]] = dmem_wdata_o;
                end
            end else begin
                dmem_ready_i = 1'b0;
                stall_left--;
                stalls++;
            end
            held_valid = !dmem_ready_i;
            held_we    = dmem_we_o;
            held_addr  = dmem_addr_o;
            held_wdata = dmem_wdata_o;
        end else begin
            dmem_ready_i = 1'b0;
            held_valid   = 1'b0;
        end
    endtask

    task automatic reset_core();
        arst_n_i     = 1'b0;
        dmem_ready_i = 1'b0;
        repeat (4) begin
            @(negedge clk_i);
            check_eq("imem_addr_o", imem_addr_o, RESET_PC);
            check_eq("retire_valid_o", retire_valid_o, 1'b0);
            check_eq("dmem_req_valid_o", dmem_req_valid_o, 1'b0);
        end
        imem_rdata_i = fetch_word(imem_addr_o);
        arst_n_i     = 1'b1;
    endtask

    task automatic run_test(input int t);
        int errs_before;
        int last_retire;
        int retires;
        errs_before = errors;
        build_program();
        req_open   = 1'b0;
        req_done   = 1'b0;
        held_valid = 1'b0;
        stalls     = 0;
        test_cycle = 0;
        reset_core();
        last_retire = -1;
        retires     = 0;
        while (retires < RETIRES) begin
            @(negedge clk_i);
            test_cycle++;
            if (test_cycle == 1) begin
                check_eq("dmem_req_valid_o", dmem_req_valid_o, 1'b0);
            end
            // Request must not move while the memory stalls
            if (held_valid) begin
                check_eq("dmem_req_valid_o", dmem_req_valid_o, 1'b1);
                check_eq("dmem_we_o", dmem_we_o, held_we);
                check_eq("dmem_addr_o", dmem_addr_o, held_addr);
                check_eq("dmem_wdata_o", dmem_wdata_o, held_wdata);
            end
            if (retire_valid_o) begin
                check_retire(test_cycle - last_retire);
                last_retire = test_cycle;
                retires++;
            end else if (retires == 0) begin
                check_eq("imem_addr_o", imem_addr_o, RESET_PC);
            end
            drive_inputs();
        end
        if (errors != errs_before) begin
            bad_tests++;
        end
        $display("test %0d: %0d retires in %0d cycles, %0d errors",
                 t, retires, test_cycle, errors - errs_before);
        test_cycle = 0;
    endtask

    initial begin
        clk_i        = 1'b0;
        arst_n_i     = 1'b0;
        imem_rdata_i = NOP;
        dmem_ready_i = 1'b0;
        dmem_rdata_i = '0;
        rng          = 32'h5bc6961c;
        errors       = 0;
        bad_tests    = 0;
        test_cycle   = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("%0d tests run, %0d with errors, %0d failed checks",
                 NUM_TESTS, bad_tests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
